//--- src/pc_cfg.svh
////////////////////////////////////////
// build-time constants for the PC stage and timer
// include wherever the interrupt count or timer map is needed
////////////////////////////////////////
`ifndef PC_CFG_SVH
`define PC_CFG_SVH

// interrupt sources, timer sits at index 0
`define PC_NUM_IRQ 3

// timer register map, one wishbone word address bit
`define PC_TMR_ADR_COUNT 1'b0
`define PC_TMR_ADR_CMP   1'b1

// value the compare register takes out of reset
`define PC_TMR_CMP_RST 32'hffff_ffff

`endif

//--- src/pc_pkg.sv
////////////////////////////////////////
// shared types for the PC subsystem
// import with pc_pkg::* in module headers
////////////////////////////////////////
`include "pc_cfg.svh"

package pc_pkg;

	// word address, bits 31:2 of a byte address
	typedef logic [31:2] pc_t;

	// command bundle coming back from execute
	typedef struct packed {
		logic jmp_condition;
		pc_t  jmp_adr;
		logic ecall_condition;
		logic cmd_ecall;
		logic cmd_ebreak;
		logic cmd_mret;
	} ex_cmd_t;

	// csr values the stage needs, owned elsewhere
	typedef struct packed {
		pc_t  mtvec;
		pc_t  mepc;
		logic rmie;
	} csr_view_t;

	// one bit per interrupt source
	typedef logic [`PC_NUM_IRQ-1:0] irq_vec_t;

	// wishbone classic, master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic        adr;
		logic [31:0] dat;
	} wb_req_t;

	// wishbone classic, slave to master
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

//--- src/frc_timer.sv
////////////////////////////////////////
// free-running counter with compare, wishbone classic slave
// cmp_leq feeds interrupt source 0
////////////////////////////////////////
`timescale 1ns/1ps
`include "pc_cfg.svh"

module frc_timer
	import pc_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output logic    cmp_leq
);

	logic [31:0] count;
	logic [31:0] cmp;
	logic        ack;
	logic [31:0] rd_dat;
	logic        access;
	logic        wr_count;
	logic        wr_cmp;

	// new cycle seen, one ack per request
	assign access   = wb_req.cyc & wb_req.stb & ~ack;
	assign wr_count = access & wb_req.we & (wb_req.adr == `PC_TMR_ADR_COUNT);
	assign wr_cmp   = access & wb_req.we & (wb_req.adr == `PC_TMR_ADR_CMP);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= access;
	end

	// counter, a write wins over the increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			count <= 32'd0;
		else if (wr_count)
			count <= wb_req.dat;
		else
			count <= count + 32'd1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cmp <= `PC_TMR_CMP_RST;
		else if (wr_cmp)
			cmp <= wb_req.dat;
	end

	// read data sampled with the request, held through ack
	always_ff @(posedge clk) begin
		if (access & ~wb_req.we)
			rd_dat <= (wb_req.adr == `PC_TMR_ADR_CMP) ? cmp : count;
	end

	// registered compare level
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cmp_leq <= 1'b0;
		else
			cmp_leq <= (cmp <= count);
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_dat;

endmodule

//--- src/irq_edge_latch.sv
////////////////////////////////////////
// one interrupt source: rising edge to sticky pending
// pending drops on the next PC stage strobe
////////////////////////////////////////
`timescale 1ns/1ps

module irq_edge_latch (
	input  logic clk,
	input  logic rst_n,
	input  logic level,
	input  logic rmie,
	input  logic stage_pc,
	output logic pending
);

	logic gated;
	logic gated_q;
	logic rise;

	// only edges seen with interrupts enabled count
	assign gated = level & rmie;
	assign rise  = gated & ~gated_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			gated_q <= 1'b0;
		else
			gated_q <= gated;
	end

	// new edge beats the strobe clear
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= 1'b0;
		else if (rise)
			pending <= 1'b1;
		else if (stage_pc)
			pending <= 1'b0;
	end

endmodule

//--- src/pc_stage.sv
////////////////////////////////////////
// PC register and next-PC select for the multi-cycle core
// steps on stage_pc, traps vector to mtvec
////////////////////////////////////////
`timescale 1ns/1ps

module pc_stage
	import pc_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cpu_start,
	input  logic      stage_pc,
	input  pc_t       cpu_start_adr,
	input  ex_cmd_t   ex,
	input  csr_view_t csr,
	input  logic      g_exception,
	input  irq_vec_t  irq_pending,
	input  irq_vec_t  irq_level,
	output pc_t       pc,
	output pc_t       pc_excep,
	output pc_t       pc_ebreak,
	output logic      cmd_ecall_pc,
	output logic      cmd_ebreak_pc,
	output logic      irq_taken
);

	logic ecall_keep;
	logic ebreak_keep;
	logic start_ld;
	logic irq_mskd;
	logic trap;
	pc_t  pc_p1;
	pc_t  pc_next;

	// ecall keeper, held until the stage comes round
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ecall_keep <= 1'b0;
		else if (stage_pc)
			ecall_keep <= 1'b0;
		else if (ex.cmd_ecall)
			ecall_keep <= 1'b1;
	end

	// same for ebreak
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ebreak_keep <= 1'b0;
		else if (stage_pc)
			ebreak_keep <= 1'b0;
		else if (ex.cmd_ebreak)
			ebreak_keep <= 1'b1;
	end

	// start address waits for the first strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			start_ld <= 1'b0;
		else if (stage_pc)
			start_ld <= 1'b0;
		else if (cpu_start)
			start_ld <= 1'b1;
	end

	assign irq_mskd  = (|irq_pending) & csr.rmie;
	assign irq_taken = irq_mskd & stage_pc;

	// an interrupt in this strobe suppresses ecall/ebreak
	assign cmd_ecall_pc  = stage_pc & ecall_keep & csr.rmie & ~irq_taken;
	assign cmd_ebreak_pc = stage_pc & ebreak_keep & csr.rmie & ~irq_taken;

	assign trap  = ex.ecall_condition | g_exception | irq_mskd;
	assign pc_p1 = pc + 30'd1;

	// mret first, then trap, then branch
	always_comb begin
		if (ex.cmd_mret)
			pc_next = csr.mepc;
		else if (trap)
			pc_next = csr.mtvec;
		else if (ex.jmp_condition)
			pc_next = ex.jmp_adr;
		else
			pc_next = pc_p1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= 30'd0;
		else if (stage_pc & start_ld)
			pc <= cpu_start_adr;
		else if (stage_pc)
			pc <= pc_next;
	end

	// return address for mepc
	// ecall without a live interrupt line returns to itself
	assign pc_excep = (ex.ecall_condition & ~(|irq_level)) ? pc :
	                  ex.jmp_condition ? ex.jmp_adr : pc_p1;

	// ebreak reports the current pc
	assign pc_ebreak = pc;

endmodule

//--- src/pc_subsys_top.sv
////////////////////////////////////////
// PC stage with timer and interrupt edge latches
// top level for simulation and integration
////////////////////////////////////////
`timescale 1ns/1ps
`include "pc_cfg.svh"

module pc_subsys_top
	import pc_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cpu_start,
	input  logic                   stage_pc,
	input  pc_t                    cpu_start_adr,
	input  ex_cmd_t                ex,
	input  csr_view_t              csr,
	input  logic                   g_exception,
	input  logic [`PC_NUM_IRQ-2:0] ext_irq,
	input  wb_req_t                wb_req,
	output wb_rsp_t                wb_rsp,
	output pc_t                    pc,
	output pc_t                    pc_excep,
	output pc_t                    pc_ebreak,
	output logic                   cmd_ecall_pc,
	output logic                   cmd_ebreak_pc,
	output logic                   irq_taken
);

	logic     cmp_leq;
	irq_vec_t irq_level;
	irq_vec_t irq_pending;

	frc_timer frc_timer_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.cmp_leq (cmp_leq)
	);

	// timer is source 0, external lines above it
	assign irq_level = {ext_irq, cmp_leq};

	for (genvar i = 0; i < `PC_NUM_IRQ; i++) begin : g_irq
		irq_edge_latch irq_edge_latch_i (
			.clk      (clk),
			.rst_n    (rst_n),
			.level    (irq_level[i]),
			.rmie     (csr.rmie),
			.stage_pc (stage_pc),
			.pending  (irq_pending[i])
		);
	end

	pc_stage pc_stage_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_start     (cpu_start),
		.stage_pc      (stage_pc),
		.cpu_start_adr (cpu_start_adr),
		.ex            (ex),
		.csr           (csr),
		.g_exception   (g_exception),
		.irq_pending   (irq_pending),
		.irq_level     (irq_level),
		.pc            (pc),
		.pc_excep      (pc_excep),
		.pc_ebreak     (pc_ebreak),
		.cmd_ecall_pc  (cmd_ecall_pc),
		.cmd_ebreak_pc (cmd_ebreak_pc),
		.irq_taken     (irq_taken)
	);

endmodule

//--- bench/pc_subsys_assertions.sv
////////////////////////////////////////
// concurrent checks bound into pc_subsys_top
////////////////////////////////////////
`timescale 1ns/1ps

module pc_subsys_assertions
	import pc_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      stage_pc,
	input pc_t       pc,
	input csr_view_t csr,
	input wb_req_t   wb_req,
	input wb_rsp_t   wb_rsp,
	input logic      irq_taken
);

	// pc moves only on an edge that saw the strobe
	a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
		(pc != $past(pc)) |-> $past(stage_pc))
		else $error("pc changed without stage_pc");

	// ack only follows a live request
	a_wb_ack: assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |-> $past(wb_req.cyc & wb_req.stb))
		else $error("ack without cyc and stb");

	a_irq_take: assert property (@(posedge clk) disable iff (!rst_n)
		irq_taken |-> (stage_pc & csr.rmie))
		else $error("irq_taken outside an enabled strobe");

endmodule

bind pc_subsys_top pc_subsys_assertions pc_subsys_assertions_i (.*);

//--- bench/tb_pc_subsys.sv
////////////////////////////////////////
// directed testbench for the PC subsystem
// compile with filelist.f, verdict on the last lines
////////////////////////////////////////
`timescale 1ns/1ps
`include "pc_cfg.svh"

module tb_pc_subsys
	import pc_pkg::*;
();

	localparam int CLK_NS = 8;
	// per-test cycle budgets, summed
	localparam int TEST_CYCLES = 60 + 40 + 60 + 80 + 300 + 60;

	logic clk = 1'b0;
	logic rst_n, cpu_start, stage_pc, g_exception;
	logic [`PC_NUM_IRQ-2:0] ext_irq;
	pc_t cpu_start_adr, pc, pc_excep, pc_ebreak;
	ex_cmd_t ex;
	csr_view_t csr;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic cmd_ecall_pc, cmd_ebreak_pc, irq_taken;

	int mism_cnt;
	int other_cnt;
	int unsigned cycle_cnt = 0;
	// comb outputs caught during the last strobe
	logic s_taken, s_ecall, s_ebreak;
	pc_t s_excep, s_ebreak_adr, pc_before;
	logic [31:0] rdat;

	pc_subsys_top pc_subsys_top_i (.*);

	initial forever #(CLK_NS / 2) clk = ~clk;

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic cmp_pc(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			mism_cnt++;
		end
	endtask

	task automatic cmp_wb_dat(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			mism_cnt++;
		end
	endtask

	task automatic cmp_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			mism_cnt++;
		end
	endtask

	// one strobe cycle, then one idle cycle
	task automatic strobe(input ex_cmd_t cmd);
		@(negedge clk);
		ex = cmd;
		stage_pc = 1'b1;
		pc_before = pc;
		#1;
		s_taken = irq_taken;
		s_ecall = cmd_ecall_pc;
		s_ebreak = cmd_ebreak_pc;
		s_excep = pc_excep;
		s_ebreak_adr = pc_ebreak;
		@(negedge clk);
		stage_pc = 1'b0;
		ex = '0;
	endtask

	// classic single transfer, stb dropped the cycle after ack
	task automatic wb_xfer(input logic we, input logic adr, input logic [31:0] wdat,
			output int unsigned ack_cyc);
		int n;
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_rsp.ack && n < 4);
		if (!wb_rsp.ack) begin
			$display("no acknowledge from the timer within 4 cycles");
			other_cnt++;
		end
		rdat = wb_rsp.dat;
		ack_cyc = cycle_cnt;
		wb_req = '0;
	endtask

	// compare a little above count, then idle strobes until a trap or give up
	task automatic arm_timer(output int polls);
		int unsigned c;
		wb_xfer(1'b1, `PC_TMR_ADR_COUNT, 32'd100, c);
		wb_xfer(1'b1, `PC_TMR_ADR_CMP, 32'd140, c);
		polls = 0;
		do begin
			strobe('0);
			polls++;
		end while (!s_taken && polls < 40);
	endtask

	task automatic reset_and_start();
		pc_t start;
		start = pc_t'($urandom);
		cmp_pc("pc", pc, '0);
		cmp_bit("irq_taken", irq_taken, 1'b0);
		cmp_bit("cmd_ecall_pc", cmd_ecall_pc, 1'b0);
		cmp_bit("cmd_ebreak_pc", cmd_ebreak_pc, 1'b0);
		cmp_bit("wb_rsp.ack", wb_rsp.ack, 1'b0);
		cpu_start_adr = start;
		cpu_start = 1'b1;
		@(negedge clk);
		cpu_start = 1'b0;
		strobe('0);
		cmp_pc("pc", pc, start);
		repeat (3) begin
			strobe('0);
			cmp_pc("pc", pc, pc_before + 30'd1);
		end
		// no strobe, pc holds
		pc_before = pc;
		repeat (5) @(negedge clk);
		cmp_pc("pc", pc, pc_before);
	endtask

	task automatic jump_and_return();
		ex_cmd_t cmd;
		cmd = '0;
		cmd.jmp_condition = 1'b1;
		cmd.jmp_adr = pc_t'($urandom);
		strobe(cmd);
		cmp_pc("pc_excep", s_excep, cmd.jmp_adr);
		cmp_pc("pc", pc, cmd.jmp_adr);
		strobe('0);
		cmp_pc("pc_excep", s_excep, pc_before + 30'd1);
		// mret wins over the branch still asserted
		cmd.cmd_mret = 1'b1;
		strobe(cmd);
		cmp_pc("pc", pc, csr.mepc);
	endtask

	task automatic ecall_ebreak();
		ex_cmd_t cmd;
		pc_t exp_pc;
		cmd = '0;
		cmd.ecall_condition = 1'b1;
		strobe(cmd);
		cmp_pc("pc_excep", s_excep, pc_before);
		cmp_pc("pc", pc, csr.mtvec);
		// each idle strobe below steps pc by one from mtvec
		exp_pc = csr.mtvec;
		// enabled pass first, then masked
		for (int en = 1; en >= 0; en--) begin
			csr.rmie = en[0];
			ex.cmd_ecall = 1'b1;
			@(negedge clk);
			ex = '0;
			strobe('0);
			cmp_bit("cmd_ecall_pc", s_ecall, en[0]);
			exp_pc = exp_pc + 30'd1;
			ex.cmd_ebreak = 1'b1;
			@(negedge clk);
			ex = '0;
			strobe('0);
			cmp_bit("cmd_ebreak_pc", s_ebreak, en[0]);
			cmp_pc("pc_ebreak", s_ebreak_adr, exp_pc);
			exp_pc = exp_pc + 30'd1;
		end
	endtask

	task automatic timer_regs();
		int unsigned cw;
		int unsigned cr;
		wb_xfer(1'b1, `PC_TMR_ADR_CMP, 32'h1234_5678, cw);
		wb_xfer(1'b0, `PC_TMR_ADR_CMP, 32'd0, cr);
		cmp_wb_dat("cmp", rdat, 32'h1234_5678);
		wb_xfer(1'b1, `PC_TMR_ADR_COUNT, 32'h0000_1000, cw);
		repeat (3) @(negedge clk);
		wb_xfer(1'b0, `PC_TMR_ADR_COUNT, 32'd0, cr);
		// count runs from the write edge up to the read sample edge
		cmp_wb_dat("count", rdat, 32'h0000_1000 + cr - cw - 32'd1);
		wb_xfer(1'b1, `PC_TMR_ADR_CMP, 32'hffff_ffff, cw);
	endtask

	task automatic timer_irq();
		int polls;
		int unsigned c;
		// masked crossing first
		arm_timer(polls);
		cmp_bit("irq_taken", s_taken, 1'b0);
		wb_xfer(1'b1, `PC_TMR_ADR_CMP, 32'hffff_ffff, c);
		// let cmp_leq fall before enabling
		repeat (2) @(negedge clk);
		csr.rmie = 1'b1;
		// nothing may have latched while masked
		strobe('0);
		cmp_bit("irq_taken", s_taken, 1'b0);
		arm_timer(polls);
		if (!s_taken) begin
			$display("timer interrupt not taken within %0d strobes", polls);
			other_cnt++;
		end
		cmp_pc("pc", pc, csr.mtvec);
		csr.rmie = 1'b0;
		wb_xfer(1'b1, `PC_TMR_ADR_CMP, 32'hffff_ffff, c);
		repeat (2) @(negedge clk);
	endtask

	task automatic ext_irq_trap();
		csr.rmie = 1'b1;
		@(negedge clk);
		ext_irq[0] = 1'b1;
		repeat (3) @(negedge clk);
		strobe('0);
		cmp_bit("irq_taken", s_taken, 1'b1);
		cmp_pc("pc", pc, csr.mtvec);
		// line held high, no new edge
		repeat (3) begin
			strobe('0);
			cmp_bit("irq_taken", s_taken, 1'b0);
			cmp_pc("pc", pc, pc_before + 30'd1);
		end
		ext_irq[0] = 1'b0;
		repeat (2) @(negedge clk);
		ext_irq[0] = 1'b1;
		repeat (2) @(negedge clk);
		strobe('0);
		cmp_bit("irq_taken", s_taken, 1'b1);
		cmp_pc("pc", pc, csr.mtvec);
		ext_irq = '0;
		csr.rmie = 1'b0;
	endtask

	initial begin
		void'($urandom(62));
		mism_cnt = 0;
		other_cnt = 0;
		rst_n = 1'b0;
		cpu_start = 1'b0;
		stage_pc = 1'b0;
		g_exception = 1'b0;
		cpu_start_adr = '0;
		ex = '0;
		csr = '{mtvec: 30'h0000_0100, mepc: 30'h0000_0a40, rmie: 1'b0};
		ext_irq = '0;
		wb_req = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		reset_and_start();
		jump_and_return();
		ecall_ebreak();
		timer_regs();
		timer_irq();
		ext_irq_trap();
		$display("errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
		if (mism_cnt + other_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog, twice the summed budgets
	initial begin
		#(2 * TEST_CYCLES * CLK_NS);
		$display("timeout after %0d cycles, tests did not finish", 2 * TEST_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+src
src/pc_pkg.sv
src/frc_timer.sv
src/irq_edge_latch.sv
src/pc_stage.sv
src/pc_subsys_top.sv
bench/pc_subsys_assertions.sv
bench/tb_pc_subsys.sv

//--- Makefile
# Verilator flow for the PC subsystem

LOG = sim.log

lint:
	verilator --lint-only --timing -f filelist.f --top-module pc_subsys_top

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_pc_subsys -Mdir obj_dir
	./obj_dir/Vtb_pc_subsys | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: lint sim clean
